/* common/cheri_cap_pkg.sv */
// ########################################
// capability metadata as stored next to each
// data word in the register file
// ########################################
`default_nettype none

package cheri_cap_pkg;

  // compressed capability bounds and permissions, tag on top
  typedef struct packed {
    logic        valid;
    logic [11:0] perms;
    logic [4:0]  exp;
    logic [8:0]  base;
    logic [8:0]  top;
  } reg_cap_t;

  // untagged, no permissions, zero bounds
  localparam reg_cap_t NULL_REG_CAP = '{
    valid: 1'b0,
    perms: 12'h000,
    exp:   5'h00,
    base:  9'h000,
    top:   9'h000
  };

endpackage

`default_nettype wire

/* common/cheri_rf_defs.svh */
// ########################################
// sizes and check-code constants shared by
// the register file, its control and the tests
// ########################################
`ifndef CHERI_RF_DEFS_SVH
`define CHERI_RF_DEFS_SVH

// register count, register 0 included
`define RF_NREGS 32

// register address width
`define RF_AW 5

// data word width
`define RF_DW 32

// request check-code width and the constant folded into every code
`define RF_CODE_W 7
`define RF_CODE_SEED 7'h2a

`endif

/* common/rf_req_pkg.sv */
// ########################################
// request payloads checked by the control block
// and the flags that can raise the alert
// ########################################
`default_nettype none

`include "cheri_rf_defs.svh"

package rf_req_pkg;
  import cheri_cap_pkg::*;

  // write port request, data and capability always together
  typedef struct packed {
    logic              we;
    logic [`RF_AW-1:0] waddr;
    logic [`RF_DW-1:0] wdata;
    reg_cap_t          wcap;
  } wr_req_t;

  // tag revocation, optionally clearing the tag
  typedef struct packed {
    logic              en;
    logic              clrtag;
    logic [`RF_AW-1:0] addr;
  } trvk_req_t;

  // tag reservation for an outstanding capability load
  typedef struct packed {
    logic              en;
    logic [`RF_AW-1:0] addr;
  } trsv_req_t;

  // one flag per alert source
  typedef struct packed {
    logic wr_code;
    logic trvk_code;
    logic trsv_code;
    logic shdw;
  } alert_src_t;

endpackage

`default_nettype wire

/* common/rf_wr_if.sv */
// ########################################
// accepted register write, from the control
// block to the register file
// ########################################
`timescale 1ns/10ps
`default_nettype none

`include "cheri_rf_defs.svh"

interface rf_wr_if
  import cheri_cap_pkg::*;
();

  logic              we;
  logic [`RF_AW-1:0] waddr;
  logic [`RF_DW-1:0] wdata;
  reg_cap_t          wcap;

  // control side drives a write only once it is validated
  modport ctrl (
    output we,
    output waddr,
    output wdata,
    output wcap
  );

  modport rf (
    input we,
    input waddr,
    input wdata,
    input wcap
  );

endinterface

`default_nettype wire

/* flist.f */
+incdir+common
common/cheri_cap_pkg.sv
common/rf_req_pkg.sv
common/rf_wr_if.sv
src/rf_code_chk.sv
src/rf_ctrl.sv
regfile/cheri_regfile.sv
regfile/reg_rdy_tracker.sv
src/cheri_rf_top.sv
sim/cheri_rf_props.sv
sim/cheri_rf_tb.sv

/* regfile/cheri_regfile.sv */
// ########################################
// data and capability storage with two
// combinational read ports and one write port
// ########################################
`timescale 1ns/10ps
`default_nettype none

`include "cheri_rf_defs.svh"

module cheri_regfile
  import cheri_cap_pkg::*;
(
  input  wire logic              clk_i,
  input  wire logic              rst_ni,

  rf_wr_if.rf                    wr,

  input  wire logic [`RF_AW-1:0] raddr_a_i,
  input  wire logic [`RF_AW-1:0] raddr_b_i,
  output logic      [`RF_DW-1:0] rdata_a_o,
  output logic      [`RF_DW-1:0] rdata_b_o,
  output reg_cap_t               rcap_a_o,
  output reg_cap_t               rcap_b_o,

  input  wire logic              rvk_en_i,
  input  wire logic              rvk_clrtag_i,
  input  wire logic [`RF_AW-1:0] rvk_addr_i
);

  logic [`RF_DW-1:0] rf_data [`RF_NREGS];
  reg_cap_t          rf_cap  [`RF_NREGS];

  logic              rvk_clr;

  assign rvk_clr = rvk_en_i & rvk_clrtag_i;

  // register 0 is hard-wired, no storage
  assign rf_data[0] = '0;
  assign rf_cap[0]  = NULL_REG_CAP;

  for (genvar i = 1; i < `RF_NREGS; i++) begin : g_regs
    localparam logic [`RF_AW-1:0] IDX = i;

    logic              wr_hit;
    logic              clr_hit;
    logic [`RF_DW-1:0] data_q;
    reg_cap_t          cap_q;
    reg_cap_t          cap_d;

    assign wr_hit  = wr.we & (wr.waddr == IDX);
    assign clr_hit = rvk_clr & (rvk_addr_i == IDX);

    // tag clear beats a same-cycle write, the other fields still load
    always_comb begin
      cap_d = cap_q;
      if (wr_hit) begin
        cap_d = wr.wcap;
      end
      if (clr_hit) begin
        cap_d.valid = 1'b0;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        data_q <= '0;
      end else if (wr_hit) begin
        data_q <= wr.wdata;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cap_q <= NULL_REG_CAP;
      end else if (wr_hit || clr_hit) begin
        cap_q <= cap_d;
      end
    end

    assign rf_data[i] = data_q;
    assign rf_cap[i]  = cap_q;
  end

  assign rdata_a_o = rf_data[raddr_a_i];
  assign rdata_b_o = rf_data[raddr_b_i];

  // revocation bypass, the cleared tag shows before it is stored
  always_comb begin
    rcap_a_o = rf_cap[raddr_a_i];
    if (rvk_clr && (rvk_addr_i == raddr_a_i)) begin
      rcap_a_o.valid = 1'b0;
    end

    rcap_b_o = rf_cap[raddr_b_i];
    if (rvk_clr && (rvk_addr_i == raddr_b_i)) begin
      rcap_b_o.valid = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* regfile/reg_rdy_tracker.sv */
// ########################################
// per-register ready vector for load-barrier
// revocation, with a delayed shadow check
// ########################################
`timescale 1ns/10ps
`default_nettype none

`include "cheri_rf_defs.svh"

module reg_rdy_tracker (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 rsv_en_i,
  input  wire logic [`RF_AW-1:0]    rsv_addr_i,
  input  wire logic                 rvk_en_i,
  input  wire logic [`RF_AW-1:0]    rvk_addr_i,
  output logic      [`RF_NREGS-1:0] reg_rdy_o,
  output logic                      shdw_err_o
);

  logic [`RF_NREGS-1:0] rvk_dec;
  logic [`RF_NREGS-1:0] rdy_q;
  logic [`RF_NREGS-1:0] rdy_qq;
  logic [`RF_NREGS-1:0] shdw_q;
  logic                 rsv_en_q;
  logic [`RF_AW-1:0]    rsv_addr_q;
  logic                 rvk_en_q;
  logic [`RF_AW-1:0]    rvk_addr_q;

  // reservation wins, register 0 stays ready
  function automatic logic [`RF_NREGS-1:0] rdy_next(
    input logic [`RF_NREGS-1:0] cur,
    input logic                 rsv_en,
    input logic [`RF_AW-1:0]    rsv_addr,
    input logic                 rvk_en,
    input logic [`RF_AW-1:0]    rvk_addr
  );
    logic [`RF_NREGS-1:0] set_v;
    logic [`RF_NREGS-1:0] clr_v;
    set_v = rvk_en ? (`RF_NREGS'(1) << rvk_addr) : '0;
    clr_v = rsv_en ? (`RF_NREGS'(1) << rsv_addr) : '0;
    return ((cur | set_v) & ~clr_v) | `RF_NREGS'(1);
  endfunction

  assign rvk_dec = rvk_en_i ? (`RF_NREGS'(1) << rvk_addr_i) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdy_q <= '1;
    end else if (rsv_en_i || rvk_en_i) begin
      rdy_q <= rdy_next(rdy_q, rsv_en_i, rsv_addr_i, rvk_en_i, rvk_addr_i);
    end
  end

  // revoked bit reads ready in the same cycle
  assign reg_rdy_o = rdy_q | rvk_dec;

  // shadow copy runs one cycle behind from its own request flops
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsv_en_q   <= 1'b0;
      rsv_addr_q <= '0;
      rvk_en_q   <= 1'b0;
      rvk_addr_q <= '0;
      rdy_qq     <= '1;
      shdw_q     <= '1;
    end else begin
      rsv_en_q   <= rsv_en_i;
      rsv_addr_q <= rsv_addr_i;
      rvk_en_q   <= rvk_en_i;
      rvk_addr_q <= rvk_addr_i;
      rdy_qq     <= rdy_q;
      shdw_q     <= rdy_next(shdw_q, rsv_en_q, rsv_addr_q, rvk_en_q, rvk_addr_q);
    end
  end

  assign shdw_err_o = (shdw_q != rdy_qq);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cheri_rf_tb \
  -f flist.f -o cheri_rf_sim > build.log 2>&1 \
  || { cat build.log; echo "BUILD FAILED"; exit 1; }
./obj_dir/cheri_rf_sim > sim.log 2>&1
cat sim.log
grep -qx "all tests passed" sim.log && echo "PASS" \
  || { echo "FAIL"; exit 1; }

/* sim/cheri_rf_props.sv */
// ########################################
// concurrent checks on register-file internals
// bound into every cheri_regfile instance
// ########################################
`timescale 1ns/10ps
`default_nettype none

`include "cheri_rf_defs.svh"

module cheri_rf_props
  import cheri_cap_pkg::*;
(
  input wire logic              clk_i,
  input wire logic              rst_ni,
  input wire reg_cap_t          caps_i [`RF_NREGS],
  input wire logic              rvk_en_i,
  input wire logic              rvk_clrtag_i,
  input wire logic [`RF_AW-1:0] rvk_addr_i,
  input wire logic [`RF_AW-1:0] raddr_a_i,
  input wire logic [`RF_DW-1:0] rdata_a_i,
  input wire reg_cap_t          rcap_a_i
);

  logic              clr_q;
  logic [`RF_AW-1:0] clr_addr_q;

  // last cycle's tag-clearing revocation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clr_q      <= 1'b0;
      clr_addr_q <= '0;
    end else begin
      clr_q      <= rvk_en_i & rvk_clrtag_i;
      clr_addr_q <= rvk_addr_i;
    end
  end

  // register 0 seen through the read path
  reg0_fixed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (raddr_a_i == '0) |-> (rdata_a_i == '0) && (rcap_a_i == NULL_REG_CAP))
    else $error("register 0 reads a nonzero value");

  tag_cleared: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clr_q |-> !caps_i[clr_addr_q].valid)
    else $error("revoked register still tagged one cycle later");

endmodule

bind cheri_regfile cheri_rf_props u_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .caps_i       (rf_cap),
  .rvk_en_i     (rvk_en_i),
  .rvk_clrtag_i (rvk_clrtag_i),
  .rvk_addr_i   (rvk_addr_i),
  .raddr_a_i    (raddr_a_i),
  .rdata_a_i    (rdata_a_o),
  .rcap_a_i     (rcap_a_o)
);

`default_nettype wire

/* sim/cheri_rf_tb.sv */
// ########################################
// testbench for the capability register file
// random and directed requests against a model
// ########################################
`timescale 1ns/10ps
`default_nettype none

`include "cheri_rf_defs.svh"

module cheri_rf_tb
  import cheri_cap_pkg::*;
();

  localparam int N_RANDOM    = 2000;
  localparam int MAX_CYCLES  = 4000;
  localparam int CODE_SLICES = 11;
  localparam int FOLD_W      = CODE_SLICES * `RF_CODE_W;

  logic                  clk;
  logic                  rst_n;
  logic [`RF_AW-1:0]     raddr_a;
  logic [`RF_AW-1:0]     raddr_b;
  logic [`RF_DW-1:0]     rdata_a;
  logic [`RF_DW-1:0]     rdata_b;
  reg_cap_t              rcap_a;
  reg_cap_t              rcap_b;
  logic                  we;
  logic [`RF_AW-1:0]     waddr;
  logic [`RF_DW-1:0]     wdata;
  reg_cap_t              wcap;
  logic [`RF_CODE_W-1:0] wcode;
  logic                  trvk_en;
  logic                  trvk_clrtag;
  logic [`RF_AW-1:0]     trvk_addr;
  logic [`RF_CODE_W-1:0] trvk_code;
  logic                  trsv_en;
  logic [`RF_AW-1:0]     trsv_addr;
  logic [`RF_CODE_W-1:0] trsv_code;
  logic [`RF_NREGS-1:0]  reg_rdy;
  logic                  alert;

  // corrupt the code of the matching request
  logic                  wbad;
  logic                  rvk_bad;
  logic                  rsv_bad;

  // reference model
  logic [`RF_DW-1:0]     m_data [`RF_NREGS];
  reg_cap_t              m_cap  [`RF_NREGS];
  logic [`RF_NREGS-1:0]  m_rdy;
  logic                  m_alert;

  string                 test_name;
  logic [`RF_AW-1:0]     last_waddr;
  int unsigned           cyc_cnt = 0;

  cheri_rf_top dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .raddr_a_i     (raddr_a),
    .raddr_b_i     (raddr_b),
    .rdata_a_o     (rdata_a),
    .rdata_b_o     (rdata_b),
    .rcap_a_o      (rcap_a),
    .rcap_b_o      (rcap_b),
    .we_i          (we),
    .waddr_i       (waddr),
    .wdata_i       (wdata),
    .wcap_i        (wcap),
    .wcode_i       (wcode),
    .trvk_en_i     (trvk_en),
    .trvk_clrtag_i (trvk_clrtag),
    .trvk_addr_i   (trvk_addr),
    .trvk_code_i   (trvk_code),
    .trsv_en_i     (trsv_en),
    .trsv_addr_i   (trsv_addr),
    .trsv_code_i   (trsv_code),
    .reg_rdy_o     (reg_rdy),
    .alert_o       (alert)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= MAX_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("tests failed");
      $fatal(1, "timeout");
    end
  end

  // seed XOR all 7-bit slices, payload zero-extended from the LSB
  function automatic logic [`RF_CODE_W-1:0] fold_code(input logic [FOLD_W-1:0] bits);
    logic [`RF_CODE_W-1:0] acc;
    acc = `RF_CODE_SEED;
    for (int s = 0; s < CODE_SLICES; s++) begin
      acc = acc ^ bits[s*`RF_CODE_W +: `RF_CODE_W];
    end
    return acc;
  endfunction

  function automatic reg_cap_t rand_cap();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return reg_cap_t'(r[35:0]);
  endfunction

  // half the addresses in a small range for more collisions
  function automatic logic [`RF_AW-1:0] rand_addr();
    logic [31:0] r;
    r = $urandom;
    return r[8] ? `RF_AW'(r[2:0]) : r[`RF_AW-1:0];
  endfunction

  task automatic check_eq(input string what, input logic [63:0] exp_v,
                          input logic [63:0] got_v);
    assert (got_v === exp_v) else begin
      $display("ERROR %s: %s expected %h actual %h", test_name, what, exp_v, got_v);
      $display("tests failed");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  task automatic idle();
    we          = 1'b0;
    waddr       = '0;
    wdata       = '0;
    wcap        = NULL_REG_CAP;
    wbad        = 1'b0;
    trvk_en     = 1'b0;
    trvk_clrtag = 1'b0;
    trvk_addr   = '0;
    rvk_bad     = 1'b0;
    trsv_en     = 1'b0;
    trsv_addr   = '0;
    rsv_bad     = 1'b0;
  endtask

  task automatic next_cycle();
    @(negedge clk);
    idle();
  endtask

  task automatic reset_model();
    for (int i = 0; i < `RF_NREGS; i++) begin
      m_data[i] = '0;
      m_cap[i]  = NULL_REG_CAP;
    end
    m_rdy   = '1;
    m_alert = 1'b0;
  endtask

  // codes, checks of this cycle, then model state for the next edge
  task automatic apply_and_check();
    logic [`RF_CODE_W-1:0] flip;
    logic [`RF_NREGS-1:0]  rvk_vec;
    reg_cap_t              exp_a;
    reg_cap_t              exp_b;
    logic                  wr_ok;
    logic                  rvk_ok;
    logic                  rsv_ok;
    flip      = `RF_CODE_W'(1 + ($urandom % 127));
    wcode     = fold_code(FOLD_W'({we, waddr, wdata, wcap})) ^ (wbad ? flip : '0);
    trvk_code = fold_code(FOLD_W'({trvk_en, trvk_clrtag, trvk_addr})) ^ (rvk_bad ? flip : '0);
    trsv_code = fold_code(FOLD_W'({trsv_en, trsv_addr})) ^ (rsv_bad ? flip : '0);
    wr_ok  = we && !wbad;
    rvk_ok = trvk_en && !rvk_bad;
    rsv_ok = trsv_en && !rsv_bad;
    #2;
    rvk_vec = '0;
    if (rvk_ok) begin
      rvk_vec[trvk_addr] = 1'b1;
    end
    exp_a = m_cap[raddr_a];
    exp_b = m_cap[raddr_b];
    if (rvk_ok && trvk_clrtag && trvk_addr == raddr_a) begin
      exp_a.valid = 1'b0;
    end
    if (rvk_ok && trvk_clrtag && trvk_addr == raddr_b) begin
      exp_b.valid = 1'b0;
    end
    check_eq("rdata_a", 64'(m_data[raddr_a]), 64'(rdata_a));
    check_eq("rdata_b", 64'(m_data[raddr_b]), 64'(rdata_b));
    check_eq("rcap_a", 64'(exp_a), 64'(rcap_a));
    check_eq("rcap_b", 64'(exp_b), 64'(rcap_b));
    check_eq("reg_rdy", 64'(m_rdy | rvk_vec), 64'(reg_rdy));
    check_eq("alert", 64'(m_alert), 64'(alert));

    if (wr_ok && waddr != '0) begin
      m_data[waddr] = wdata;
      m_cap[waddr]  = wcap;
    end
    // tag clear beats the write
    if (rvk_ok && trvk_clrtag && trvk_addr != '0) begin
      m_cap[trvk_addr].valid = 1'b0;
    end
    if (rvk_ok) begin
      m_rdy[trvk_addr] = 1'b1;
    end
    if (rsv_ok) begin
      m_rdy[trsv_addr] = 1'b0;
    end
    m_rdy[0] = 1'b1;
    m_alert  = (we && wbad) || (trvk_en && rvk_bad) || (trsv_en && rsv_bad);
  endtask

  task automatic rand_req();
    raddr_a     = rand_addr();
    raddr_b     = rand_addr();
    we          = ($urandom % 2) == 0;
    waddr       = rand_addr();
    wdata       = $urandom;
    wcap        = rand_cap();
    wbad        = ($urandom % 8) == 0;
    trvk_en     = ($urandom % 4) == 0;
    trvk_clrtag = ($urandom % 2) == 0;
    trvk_addr   = rand_addr();
    rvk_bad     = ($urandom % 8) == 0;
    trsv_en     = ($urandom % 4) == 0;
    trsv_addr   = rand_addr();
    rsv_bad     = ($urandom % 8) == 0;
  endtask

  initial begin
    reg_cap_t cap_v;
    void'($urandom(32'h166a_b47b));
    clk        = 1'b0;
    rst_n      = 1'b0;
    raddr_a    = '0;
    raddr_b    = '0;
    wcode      = '0;
    trvk_code  = '0;
    trsv_code  = '0;
    last_waddr = '0;
    idle();
    reset_model();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    test_name = "reset";
    for (int i = 0; i < `RF_NREGS; i++) begin
      next_cycle();
      raddr_a = `RF_AW'(i);
      raddr_b = `RF_AW'(`RF_NREGS - 1 - i);
      apply_and_check();
    end

    // every 8th write targets register 0
    test_name = "write";
    for (int i = 0; i < 64; i++) begin
      next_cycle();
      raddr_a    = last_waddr;
      raddr_b    = (i % 2 == 1) ? last_waddr : rand_addr();
      we         = 1'b1;
      waddr      = (i % 8 == 0) ? '0 : rand_addr();
      wdata      = $urandom;
      wcap       = rand_cap();
      last_waddr = waddr;
      apply_and_check();
    end

    test_name = "revoke";
    cap_v       = rand_cap();
    cap_v.valid = 1'b1;
    next_cycle();
    we      = 1'b1;
    waddr   = 5'd5;
    wdata   = $urandom;
    wcap    = cap_v;
    apply_and_check();
    next_cycle();
    raddr_a     = 5'd5;
    raddr_b     = 5'd5;
    trvk_en     = 1'b1;
    trvk_clrtag = 1'b1;
    trvk_addr   = 5'd5;
    apply_and_check();
    next_cycle();
    apply_and_check();
    // write and tag clear on the same register
    next_cycle();
    raddr_a     = 5'd7;
    raddr_b     = 5'd7;
    we          = 1'b1;
    waddr       = 5'd7;
    wdata       = $urandom;
    wcap        = cap_v;
    trvk_en     = 1'b1;
    trvk_clrtag = 1'b1;
    trvk_addr   = 5'd7;
    apply_and_check();
    next_cycle();
    apply_and_check();

    test_name = "ready";
    next_cycle();
    trsv_en   = 1'b1;
    trsv_addr = 5'd9;
    apply_and_check();
    next_cycle();
    apply_and_check();
    next_cycle();
    trvk_en   = 1'b1;
    trvk_addr = 5'd9;
    apply_and_check();
    next_cycle();
    apply_and_check();
    next_cycle();
    trsv_en   = 1'b1;
    trsv_addr = 5'd11;
    trvk_en   = 1'b1;
    trvk_addr = 5'd11;
    apply_and_check();
    next_cycle();
    apply_and_check();

    test_name = "bad_code";
    raddr_a = 5'd3;
    raddr_b = 5'd3;
    for (int k = 0; k < 4; k++) begin
      next_cycle();
      case (k)
        0: begin
          we    = 1'b1;
          waddr = 5'd3;
          wdata = $urandom;
          wcap  = cap_v;
          wbad  = 1'b1;
        end
        1: begin
          we    = 1'b1;
          waddr = 5'd3;
          wdata = $urandom;
          wcap  = cap_v;
        end
        2: begin
          trvk_en     = 1'b1;
          trvk_clrtag = 1'b1;
          trvk_addr   = 5'd3;
          rvk_bad     = 1'b1;
        end
        default: begin
          trsv_en   = 1'b1;
          trsv_addr = 5'd3;
          rsv_bad   = 1'b1;
        end
      endcase
      apply_and_check();
      next_cycle();
      apply_and_check();
    end

    test_name = "random";
    for (int i = 0; i < N_RANDOM; i++) begin
      next_cycle();
      rand_req();
      apply_and_check();
    end

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src/cheri_rf_top.sv */
// ########################################
// capability register file with load-barrier
// tag reservation and revocation ports
// ########################################
`timescale 1ns/10ps
`default_nettype none

`include "cheri_rf_defs.svh"

module cheri_rf_top
  import cheri_cap_pkg::*;
  import rf_req_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,

  input  wire logic [`RF_AW-1:0]     raddr_a_i,
  input  wire logic [`RF_AW-1:0]     raddr_b_i,
  output logic      [`RF_DW-1:0]     rdata_a_o,
  output logic      [`RF_DW-1:0]     rdata_b_o,
  output reg_cap_t                   rcap_a_o,
  output reg_cap_t                   rcap_b_o,

  input  wire logic                  we_i,
  input  wire logic [`RF_AW-1:0]     waddr_i,
  input  wire logic [`RF_DW-1:0]     wdata_i,
  input  wire reg_cap_t              wcap_i,
  input  wire logic [`RF_CODE_W-1:0] wcode_i,

  input  wire logic                  trvk_en_i,
  input  wire logic                  trvk_clrtag_i,
  input  wire logic [`RF_AW-1:0]     trvk_addr_i,
  input  wire logic [`RF_CODE_W-1:0] trvk_code_i,

  input  wire logic                  trsv_en_i,
  input  wire logic [`RF_AW-1:0]     trsv_addr_i,
  input  wire logic [`RF_CODE_W-1:0] trsv_code_i,

  output logic      [`RF_NREGS-1:0]  reg_rdy_o,
  output logic                       alert_o
);

  wr_req_t           wr_req;
  trvk_req_t         trvk_req;
  trsv_req_t         trsv_req;
  logic              rsv_en;
  logic [`RF_AW-1:0] rsv_addr;
  logic              rvk_en;
  logic              rvk_clrtag;
  logic [`RF_AW-1:0] rvk_addr;
  logic              shdw_err;

  rf_wr_if wr_if ();

  assign wr_req   = '{we: we_i, waddr: waddr_i, wdata: wdata_i, wcap: wcap_i};
  assign trvk_req = '{en: trvk_en_i, clrtag: trvk_clrtag_i, addr: trvk_addr_i};
  assign trsv_req = '{en: trsv_en_i, addr: trsv_addr_i};

  rf_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr_req_i     (wr_req),
    .wr_code_i    (wcode_i),
    .trvk_req_i   (trvk_req),
    .trvk_code_i  (trvk_code_i),
    .trsv_req_i   (trsv_req),
    .trsv_code_i  (trsv_code_i),
    .shdw_err_i   (shdw_err),
    .wr           (wr_if.ctrl),
    .rsv_en_o     (rsv_en),
    .rsv_addr_o   (rsv_addr),
    .rvk_en_o     (rvk_en),
    .rvk_clrtag_o (rvk_clrtag),
    .rvk_addr_o   (rvk_addr),
    .alert_o      (alert_o)
  );

  cheri_regfile u_regfile (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr           (wr_if.rf),
    .raddr_a_i    (raddr_a_i),
    .raddr_b_i    (raddr_b_i),
    .rdata_a_o    (rdata_a_o),
    .rdata_b_o    (rdata_b_o),
    .rcap_a_o     (rcap_a_o),
    .rcap_b_o     (rcap_b_o),
    .rvk_en_i     (rvk_en),
    .rvk_clrtag_i (rvk_clrtag),
    .rvk_addr_i   (rvk_addr)
  );

  reg_rdy_tracker u_rdy (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rsv_en_i   (rsv_en),
    .rsv_addr_i (rsv_addr),
    .rvk_en_i   (rvk_en),
    .rvk_addr_i (rvk_addr),
    .reg_rdy_o  (reg_rdy_o),
    .shdw_err_o (shdw_err)
  );

endmodule

`default_nettype wire

/* src/rf_code_chk.sv */
// ########################################
// folded XOR check code over any packed
// request payload, compared to the sent code
// ########################################
`timescale 1ns/10ps
`default_nettype none

`include "cheri_rf_defs.svh"

module rf_code_chk #(
  parameter type payload_t = logic
) (
  input  wire payload_t               payload_i,
  input  wire logic [`RF_CODE_W-1:0]  code_i,
  output logic                        err_o
);

  localparam int PW   = $bits(payload_t);
  localparam int NS   = (PW + `RF_CODE_W - 1) / `RF_CODE_W;
  localparam int PADW = NS * `RF_CODE_W;

  logic [PADW-1:0]       padded;
  logic [`RF_CODE_W-1:0] code_calc;

  // slices from the LSB up, last one zero-padded
  always_comb begin
    padded         = '0;
    padded[PW-1:0] = payload_i;
    code_calc      = `RF_CODE_SEED;
    for (int s = 0; s < NS; s++) begin
      code_calc = code_calc ^ padded[s*`RF_CODE_W +: `RF_CODE_W];
    end
  end

  assign err_o = (code_calc != code_i);

endmodule

`default_nettype wire

/* src/rf_ctrl.sv */
// ########################################
// validates write, reservation and revocation
// requests and registers the alert
// ########################################
`timescale 1ns/10ps
`default_nettype none

`include "cheri_rf_defs.svh"

module rf_ctrl
  import rf_req_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,

  input  wire wr_req_t               wr_req_i,
  input  wire logic [`RF_CODE_W-1:0] wr_code_i,
  input  wire trvk_req_t             trvk_req_i,
  input  wire logic [`RF_CODE_W-1:0] trvk_code_i,
  input  wire trsv_req_t             trsv_req_i,
  input  wire logic [`RF_CODE_W-1:0] trsv_code_i,
  input  wire logic                  shdw_err_i,

  rf_wr_if.ctrl                      wr,

  output logic                       rsv_en_o,
  output logic      [`RF_AW-1:0]     rsv_addr_o,
  output logic                       rvk_en_o,
  output logic                       rvk_clrtag_o,
  output logic      [`RF_AW-1:0]     rvk_addr_o,
  output logic                       alert_o
);

  logic       wr_err;
  logic       trvk_err;
  logic       trsv_err;
  alert_src_t alert_src;
  logic       alert_q;

  rf_code_chk #(.payload_t(wr_req_t)) u_wr_chk (
    .payload_i (wr_req_i),
    .code_i    (wr_code_i),
    .err_o     (wr_err)
  );

  rf_code_chk #(.payload_t(trvk_req_t)) u_trvk_chk (
    .payload_i (trvk_req_i),
    .code_i    (trvk_code_i),
    .err_o     (trvk_err)
  );

  rf_code_chk #(.payload_t(trsv_req_t)) u_trsv_chk (
    .payload_i (trsv_req_i),
    .code_i    (trsv_code_i),
    .err_o     (trsv_err)
  );

  // writes to register 0 are dropped here
  assign wr.we    = wr_req_i.we & ~wr_err & (wr_req_i.waddr != '0);
  assign wr.waddr = wr_req_i.waddr;
  assign wr.wdata = wr_req_i.wdata;
  assign wr.wcap  = wr_req_i.wcap;

  assign rsv_en_o     = trsv_req_i.en & ~trsv_err;
  assign rsv_addr_o   = trsv_req_i.addr;
  assign rvk_en_o     = trvk_req_i.en & ~trvk_err;
  assign rvk_clrtag_o = trvk_req_i.clrtag;
  assign rvk_addr_o   = trvk_req_i.addr;

  // only an enabled request can fail its code
  assign alert_src.wr_code   = wr_req_i.we & wr_err;
  assign alert_src.trvk_code = trvk_req_i.en & trvk_err;
  assign alert_src.trsv_code = trsv_req_i.en & trsv_err;
  assign alert_src.shdw      = shdw_err_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= |alert_src;
    end
  end

  assign alert_o = alert_q;

endmodule

`default_nettype wire
